/* snake_score_pkg.sv */
`default_nettype none

package snake_score_pkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // value types
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    typedef logic [7:0] score_t;
    typedef logic [3:0] bcd_digit_t;

    // bit 0 is segment a and bit 6 is segment g, a lit segment is 1.
    typedef logic [6:0] seg_t;

    typedef enum logic {
        PLAYING,
        OVER
    } round_state_t;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // seven-segment shapes for the digits 0 to 9
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    localparam seg_t SEG_TABLE [10] = '{
        7'h3F, 7'h06, 7'h5B, 7'h4F, 7'h66,
        7'h6D, 7'h7D, 7'h07, 7'h7F, 7'h6F
    };

endpackage

`default_nettype wire

/* score_if.sv */
`timescale 1ns/100ps
`default_nettype none

interface score_if;

    logic                    valid;
    logic                    ready;
    snake_score_pkg::score_t score;
    // set when the score is the high score shown after a round has ended.
    logic                    from_high;

    modport source (
        output valid,
        output score,
        output from_high,
        input  ready
    );

    modport sink (
        input  valid,
        input  score,
        input  from_high,
        output ready
    );

endinterface

`default_nettype wire

/* bcd_if.sv */
`timescale 1ns/100ps
`default_nettype none

interface bcd_if;

    logic                        valid;
    snake_score_pkg::bcd_digit_t hundreds;
    snake_score_pkg::bcd_digit_t tens;
    snake_score_pkg::bcd_digit_t ones;

    modport source (
        output valid,
        output hundreds,
        output tens,
        output ones
    );

    modport sink (
        input valid,
        input hundreds,
        input tens,
        input ones
    );

endinterface

`default_nettype wire

/* score_tracker.sv */
`timescale 1ns/100ps
`default_nettype none

module score_tracker #(
    parameter snake_score_pkg::score_t MAX_SCORE = 8'd140
) (
    input  logic                    clk,
    input  logic                    nRst,
    input  logic                    good_coll,
    input  logic                    bad_coll,
    output snake_score_pkg::score_t current_score,
    output snake_score_pkg::score_t high_score,
    output snake_score_pkg::score_t disp_score,
    output logic                    game_complete,
    score_if.source                 disp
);

    logic good_s;
    logic good_s_d;
    logic bad_s;
    logic good_edge;
    logic at_max;
    logic round_end;
    logic count;
    logic update;

    snake_score_pkg::round_state_t state;
    snake_score_pkg::round_state_t state_next;
    snake_score_pkg::score_t       cur_inc;
    snake_score_pkg::score_t       cur_next;
    snake_score_pkg::score_t       high_next;
    snake_score_pkg::score_t       disp_next;

    logic                    pend_valid;
    logic                    pend_high;
    snake_score_pkg::score_t pend_score;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // input sampling
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk, negedge nRst) begin
        if (!nRst) begin
            good_s   <= 1'b0;
            good_s_d <= 1'b0;
            bad_s    <= 1'b0;
        end else begin
            good_s   <= good_coll;
            good_s_d <= good_s;
            bad_s    <= bad_coll;
        end
    end

    // a held collision only scores on its first sampled cycle.
    assign good_edge = good_s & ~good_s_d;
    assign at_max    = (current_score >= MAX_SCORE);
    assign round_end = bad_s | at_max;
    // once the cap is reached the score stays put until the round is closed.
    assign count     = good_edge & ~at_max;
    assign cur_inc   = current_score + 8'd1;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // score and round state
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_comb begin
        cur_next   = current_score;
        high_next  = high_score;
        state_next = state;
        if (count) begin
            cur_next   = cur_inc;
            state_next = snake_score_pkg::PLAYING;
            if (cur_inc > high_score) begin
                high_next = cur_inc;
            end
        end
        // the point above is already in high_next when both collide at once.
        if (round_end) begin
            cur_next   = '0;
            state_next = snake_score_pkg::OVER;
        end
        disp_next = (state_next == snake_score_pkg::OVER) ? high_next : cur_next;
    end

    always_ff @(posedge clk, negedge nRst) begin
        if (!nRst) begin
            state         <= snake_score_pkg::PLAYING;
            current_score <= '0;
            high_score    <= '0;
            disp_score    <= '0;
            game_complete <= 1'b0;
        end else begin
            state         <= state_next;
            current_score <= cur_next;
            high_score    <= high_next;
            disp_score    <= disp_next;
            game_complete <= round_end;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // handoff to the converter
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    assign update = (disp_next != disp_score) || (state_next != state);

    always_ff @(posedge clk, negedge nRst) begin
        if (!nRst) begin
            pend_valid <= 1'b0;
        end else if (update) begin
            pend_valid <= 1'b1;
        end else if (disp.ready) begin
            pend_valid <= 1'b0;
        end
    end

    // a newer value simply replaces one the converter has not taken yet.
    always_ff @(posedge clk) begin
        if (update) begin
            pend_score <= disp_next;
            pend_high  <= (state_next == snake_score_pkg::OVER);
        end
    end

    assign disp.valid     = pend_valid;
    assign disp.score     = pend_score;
    assign disp.from_high = pend_high;

endmodule

`default_nettype wire

/* bcd_converter.sv */
`timescale 1ns/100ps
`default_nettype none

module bcd_converter (
    input logic   clk,
    input logic   nRst,
    score_if.sink in,
    bcd_if.source out
);

    localparam int unsigned DIGITS = 3;
    localparam int unsigned ACC_W  = 4 * DIGITS;
    localparam logic [3:0]  ITERS  = 4'($bits(snake_score_pkg::score_t));

    logic                    busy;
    logic [3:0]              step;
    logic                    done;
    logic                    accept;
    snake_score_pkg::score_t shift;
    logic [ACC_W-1:0]        acc;
    logic [ACC_W-1:0]        acc_adj;

    // digits of 5 or more get 3 added so the next shift carries correctly.
    function automatic logic [ACC_W-1:0] add3(input logic [ACC_W-1:0] v);
        logic [ACC_W-1:0] r;
        r = v;
        for (int i = 0; i < DIGITS; i++) begin
            if (v[4*i +: 4] >= 4'd5) begin
                r[4*i +: 4] = v[4*i +: 4] + 4'd3;
            end
        end
        return r;
    endfunction

    assign in.ready = ~busy & ~done;
    assign accept   = in.valid & in.ready;
    assign acc_adj  = add3(acc);

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // iteration control
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk, negedge nRst) begin
        if (!nRst) begin
            busy <= 1'b0;
            step <= '0;
            done <= 1'b0;
        end else begin
            done <= 1'b0;
            if (accept) begin
                busy <= 1'b1;
                step <= '0;
            end else if (busy) begin
                // one extra cycle after the last shift presents the result.
                if (step == ITERS) begin
                    busy <= 1'b0;
                    done <= 1'b1;
                end else begin
                    step <= step + 4'd1;
                end
            end
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // shift-and-add-three datapath
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk) begin
        if (accept) begin
            shift <= in.score;
            acc   <= '0;
        end else if (busy && step != ITERS) begin
            acc   <= {acc_adj[ACC_W-2:0], shift[$bits(shift)-1]};
            shift <= shift << 1;
        end
    end

    // acc holds still from the last shift until the next value is taken.
    assign out.valid    = done;
    assign out.hundreds = acc[11:8];
    assign out.tens     = acc[7:4];
    assign out.ones     = acc[3:0];

endmodule

`default_nettype wire

/* digit_scanner.sv */
`timescale 1ns/100ps
`default_nettype none

module digit_scanner #(
    parameter int unsigned SCAN_DIV = 4
) (
    input  logic                        clk,
    input  logic                        nRst,
    bcd_if.sink                         in,
    output snake_score_pkg::bcd_digit_t bcd_hundreds,
    output snake_score_pkg::bcd_digit_t bcd_tens,
    output snake_score_pkg::bcd_digit_t bcd_ones,
    output snake_score_pkg::seg_t       seg,
    output logic [2:0]                  digit_sel
);

    localparam int unsigned      DIV_W    = (SCAN_DIV > 1) ? $clog2(SCAN_DIV) : 1;
    localparam logic [DIV_W-1:0] DIV_LAST = DIV_W'(SCAN_DIV - 1);

    logic [DIV_W-1:0]            div_cnt;
    logic [2:0]                  sel_next;
    snake_score_pkg::bcd_digit_t hund_next;
    snake_score_pkg::bcd_digit_t tens_next;
    snake_score_pkg::bcd_digit_t ones_next;
    snake_score_pkg::bcd_digit_t shown;

    function automatic snake_score_pkg::seg_t seg_of(input snake_score_pkg::bcd_digit_t d);
        if (d > 4'd9) begin
            return '0;
        end
        return snake_score_pkg::SEG_TABLE[d];
    endfunction

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // next digits and next position
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    assign hund_next = in.valid ? in.hundreds : bcd_hundreds;
    assign tens_next = in.valid ? in.tens : bcd_tens;
    assign ones_next = in.valid ? in.ones : bcd_ones;

    // rotation runs ones, tens, hundreds and back to ones.
    assign sel_next = (div_cnt == DIV_LAST) ? {digit_sel[1:0], digit_sel[2]} : digit_sel;

    // decoding from the next values keeps seg matched to digit_sel every cycle.
    always_comb begin
        case (sel_next)
            3'b001:  shown = ones_next;
            3'b010:  shown = tens_next;
            default: shown = hund_next;
        endcase
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // registers
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk, negedge nRst) begin
        if (!nRst) begin
            bcd_hundreds <= '0;
            bcd_tens     <= '0;
            bcd_ones     <= '0;
            div_cnt      <= '0;
            digit_sel    <= 3'b001;
            seg          <= snake_score_pkg::SEG_TABLE[0];
        end else begin
            bcd_hundreds <= hund_next;
            bcd_tens     <= tens_next;
            bcd_ones     <= ones_next;
            div_cnt      <= (div_cnt == DIV_LAST) ? '0 : div_cnt + 1'b1;
            digit_sel    <= sel_next;
            seg          <= seg_of(shown);
        end
    end

endmodule

`default_nettype wire

/* snake_score_top.sv */
`timescale 1ns/100ps
`default_nettype none

module snake_score_top #(
    parameter snake_score_pkg::score_t MAX_SCORE = 8'd140,
    parameter int unsigned             SCAN_DIV  = 4
) (
    input  logic                        clk,
    input  logic                        nRst,
    input  logic                        good_coll,
    input  logic                        bad_coll,
    output snake_score_pkg::score_t     current_score,
    output snake_score_pkg::score_t     high_score,
    output snake_score_pkg::score_t     disp_score,
    output logic                        game_complete,
    output snake_score_pkg::bcd_digit_t bcd_hundreds,
    output snake_score_pkg::bcd_digit_t bcd_tens,
    output snake_score_pkg::bcd_digit_t bcd_ones,
    output snake_score_pkg::seg_t       seg,
    output logic [2:0]                  digit_sel
);

    score_if score_link ();
    bcd_if   digit_link ();

    score_tracker #(
        .MAX_SCORE (MAX_SCORE)
    ) score_tracker_i (
        .clk           (clk),
        .nRst          (nRst),
        .good_coll     (good_coll),
        .bad_coll      (bad_coll),
        .current_score (current_score),
        .high_score    (high_score),
        .disp_score    (disp_score),
        .game_complete (game_complete),
        .disp          (score_link.source)
    );

    bcd_converter bcd_converter_i (
        .clk  (clk),
        .nRst (nRst),
        .in   (score_link.sink),
        .out  (digit_link.source)
    );

    digit_scanner #(
        .SCAN_DIV (SCAN_DIV)
    ) digit_scanner_i (
        .clk          (clk),
        .nRst         (nRst),
        .in           (digit_link.sink),
        .bcd_hundreds (bcd_hundreds),
        .bcd_tens     (bcd_tens),
        .bcd_ones     (bcd_ones),
        .seg          (seg),
        .digit_sel    (digit_sel)
    );

endmodule

`default_nettype wire

/* snake_score_tb.sv */
`timescale 1ns/100ps
`default_nettype none

module snake_score_tb;

    localparam snake_score_pkg::score_t MAX_SCORE = 8'd140;
    localparam int unsigned SCAN_DIV = 4;
    // a value queued behind a running conversion needs about two conversion times.
    localparam int SETTLE_CYCLES = 24;
    localparam int SETTLE_LIMIT  = 80;
    localparam int RANDOM_CYCLES = 8000;

    localparam snake_score_pkg::seg_t SEG_REF [10] = '{
        7'h3F, 7'h06, 7'h5B, 7'h4F, 7'h66,
        7'h6D, 7'h7D, 7'h07, 7'h7F, 7'h6F
    };

    logic                        clk;
    logic                        nRst;
    logic                        good_coll;
    logic                        bad_coll;
    snake_score_pkg::score_t     current_score;
    snake_score_pkg::score_t     high_score;
    snake_score_pkg::score_t     disp_score;
    logic                        game_complete;
    snake_score_pkg::bcd_digit_t bcd_hundreds;
    snake_score_pkg::bcd_digit_t bcd_tens;
    snake_score_pkg::bcd_digit_t bcd_ones;
    snake_score_pkg::seg_t       seg;
    logic [2:0]                  digit_sel;

    int seed;
    int score_errors;
    int digit_errors;
    int seg_errors;
    int flag_errors;
    int timeout_errors;
    int total_errors;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // reference model state
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    logic                        m_good_s;
    logic                        m_good_d;
    logic                        m_bad_s;
    logic                        m_point;
    logic                        m_end;
    logic                        m_over;
    logic                        m_gc;
    snake_score_pkg::score_t     m_cur;
    snake_score_pkg::score_t     m_high;
    snake_score_pkg::score_t     m_disp;
    snake_score_pkg::score_t     last_disp;
    int                          disp_stable;
    snake_score_pkg::bcd_digit_t exp_hund;
    snake_score_pkg::bcd_digit_t exp_tens;
    snake_score_pkg::bcd_digit_t exp_ones;
    snake_score_pkg::bcd_digit_t shown;
    snake_score_pkg::seg_t       exp_seg;
    logic [2:0]                  prev_sel;
    int unsigned                 sel_hold;

    snake_score_top #(
        .MAX_SCORE (MAX_SCORE),
        .SCAN_DIV  (SCAN_DIV)
    ) snake_score_top_i (
        .clk           (clk),
        .nRst          (nRst),
        .good_coll     (good_coll),
        .bad_coll      (bad_coll),
        .current_score (current_score),
        .high_score    (high_score),
        .disp_score    (disp_score),
        .game_complete (game_complete),
        .bcd_hundreds  (bcd_hundreds),
        .bcd_tens      (bcd_tens),
        .bcd_ones      (bcd_ones),
        .seg           (seg),
        .digit_sel     (digit_sel)
    );

    always #5 clk = ~clk;

    task automatic check_score(input string what, input snake_score_pkg::score_t got,
                               input snake_score_pkg::score_t want);
        if (got !== want) begin
            score_errors++;
            $display("Error at %0t ns: %s is %0d, expected %0d", $time, what, got, want);
        end
    endtask

    task automatic check_digit(input string what, input snake_score_pkg::bcd_digit_t got,
                               input snake_score_pkg::bcd_digit_t want);
        if (got !== want) begin
            digit_errors++;
            $display("Error at %0t ns: %s is %0d, expected %0d", $time, what, got, want);
        end
    endtask

    task automatic check_seg(input string what, input snake_score_pkg::seg_t got,
                             input snake_score_pkg::seg_t want);
        if (got !== want) begin
            seg_errors++;
            $display("Error at %0t ns: %s is 7'h%h, expected 7'h%h", $time, what, got, want);
        end
    endtask

    task automatic check_flag(input string what, input logic got, input logic want);
        if (got !== want) begin
            flag_errors++;
            $display("Error at %0t ns: %s is %b, expected %b", $time, what, got, want);
        end
    endtask

    function automatic int unsigned pick_below(input int unsigned limit);
        return $unsigned($random(seed)) % limit;
    endfunction

    task automatic score_points(input int count, input int len, input int gap);
        for (int i = 0; i < count; i++) begin
            @(posedge clk);
            good_coll <= 1'b1;
            repeat (len - 1) @(posedge clk);
            @(posedge clk);
            good_coll <= 1'b0;
            repeat (gap - 1) @(posedge clk);
        end
    endtask

    task automatic collide_both();
        @(posedge clk);
        good_coll <= 1'b1;
        bad_coll  <= 1'b1;
        @(posedge clk);
        good_coll <= 1'b0;
        bad_coll  <= 1'b0;
    endtask

    task automatic wait_display_settled(input int limit);
        int  waited;
        logic settled;
        waited  = 0;
        settled = 1'b0;
        while (!settled && waited < limit) begin
            @(negedge clk);
            waited++;
            settled = (disp_stable >= SETTLE_CYCLES) && (bcd_hundreds == exp_hund) &&
                      (bcd_tens == exp_tens) && (bcd_ones == exp_ones);
        end
        if (!settled) begin
            timeout_errors++;
            $display("Timeout: display digits did not settle on score %0d within %0d cycles",
                     m_disp, limit);
        end
    endtask

    task automatic random_play(input int cycles);
        int good_len;
        int good_gap;
        int bad_len;
        good_len = 0;
        good_gap = 0;
        bad_len  = 0;
        for (int cyc = 0; cyc < cycles; cyc++) begin
            @(posedge clk);
            if (good_len > 0) begin
                good_coll <= 1'b1;
                good_len = good_len - 1;
            end else if (good_gap > 0) begin
                good_coll <= 1'b0;
                good_gap = good_gap - 1;
            end else begin
                good_coll <= 1'b1;
                good_len = pick_below(5);
                // now and then a long pause lets the display catch up.
                if (pick_below(8) == 0) begin
                    good_gap = 16 + pick_below(24);
                end else begin
                    good_gap = 1 + pick_below(7);
                end
            end
            if (bad_len > 0) begin
                bad_coll <= 1'b1;
                bad_len = bad_len - 1;
            end else begin
                bad_coll <= 1'b0;
                if (pick_below(1500) == 0) begin
                    bad_len = 1 + pick_below(2);
                end
            end
        end
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // cycle model of the scoring rules
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always @(posedge clk) begin
        if (!nRst) begin
            m_good_s = 1'b0;
            m_good_d = 1'b0;
            m_bad_s  = 1'b0;
            m_over   = 1'b0;
            m_gc     = 1'b0;
            m_cur    = '0;
            m_high   = '0;
            m_disp   = '0;
        end else begin
            // a point needs a fresh press and room below the cap.
            m_point = m_good_s && !m_good_d && (m_cur != MAX_SCORE);
            m_end   = m_bad_s || (m_cur == MAX_SCORE);
            if (m_point) begin
                m_cur  = m_cur + 8'd1;
                m_over = 1'b0;
                if (m_cur > m_high) begin
                    m_high = m_cur;
                end
            end
            if (m_end) begin
                m_cur  = '0;
                m_over = 1'b1;
            end
            m_gc     = m_end;
            m_disp   = m_over ? m_high : m_cur;
            m_good_d = m_good_s;
            m_good_s = good_coll;
            m_bad_s  = bad_coll;
        end
    end

    always @(negedge clk) begin
        if (nRst) begin
            check_score("current_score", current_score, m_cur);
            check_score("high_score", high_score, m_high);
            check_score("disp_score", disp_score, m_disp);
            check_flag("game_complete", game_complete, m_gc);

            disp_stable = (m_disp == last_disp) ? disp_stable + 1 : 0;
            last_disp   = m_disp;
            exp_hund    = 4'(m_disp / 8'd100);
            exp_tens    = 4'((m_disp / 8'd10) % 8'd10);
            exp_ones    = 4'(m_disp % 8'd10);
            if (disp_stable >= SETTLE_CYCLES) begin
                check_digit("bcd_hundreds", bcd_hundreds, exp_hund);
                check_digit("bcd_tens", bcd_tens, exp_tens);
                check_digit("bcd_ones", bcd_ones, exp_ones);
            end

            case (digit_sel)
                3'b001:  shown = bcd_ones;
                3'b010:  shown = bcd_tens;
                default: shown = bcd_hundreds;
            endcase
            check_flag("selected digit in 0 to 9", shown <= 4'd9, 1'b1);
            if (shown <= 4'd9) begin
                exp_seg = SEG_REF[shown];
                check_seg("seg", seg, exp_seg);
            end
            check_flag("digit_sel one-hot", $onehot(digit_sel), 1'b1);
            if (digit_sel == prev_sel) begin
                sel_hold = sel_hold + 1;
                check_flag("digit_sel held at most SCAN_DIV cycles", sel_hold <= SCAN_DIV, 1'b1);
            end else begin
                check_flag("digit_sel order", digit_sel == {prev_sel[1:0], prev_sel[2]}, 1'b1);
                check_flag("digit_sel held SCAN_DIV cycles", sel_hold == SCAN_DIV, 1'b1);
                sel_hold = 1;
            end
            prev_sel = digit_sel;
        end
    end

    initial begin
        clk            = 1'b0;
        nRst           = 1'b0;
        good_coll      = 1'b0;
        bad_coll       = 1'b0;
        seed           = 32'h2bbc_ec54;
        score_errors   = 0;
        digit_errors   = 0;
        seg_errors     = 0;
        flag_errors    = 0;
        timeout_errors = 0;
        prev_sel       = 3'b001;
        sel_hold       = 0;
        last_disp      = '0;
        disp_stable    = 0;
        repeat (5) @(posedge clk);
        nRst <= 1'b1;

        // three short presses, then one long press that scores once.
        score_points(3, 1, 2);
        score_points(1, 6, 3);
        wait_display_settled(SETTLE_LIMIT);

        collide_both();
        @(posedge clk);
        @(negedge clk);
        check_score("high_score after joint collision", high_score, 8'd5);
        check_score("current_score after joint collision", current_score, 8'd0);
        wait_display_settled(SETTLE_LIMIT);

        // back-to-back points arrive faster than the converter finishes.
        score_points(12, 1, 1);
        wait_display_settled(SETTLE_LIMIT);
        score_points(150, 1, 1);
        wait_display_settled(SETTLE_LIMIT);

        random_play(RANDOM_CYCLES);
        @(posedge clk);
        good_coll <= 1'b0;
        bad_coll  <= 1'b0;
        wait_display_settled(SETTLE_LIMIT);

        total_errors = score_errors + digit_errors + seg_errors + flag_errors + timeout_errors;
        $display("errors: score %0d, digit %0d, seg %0d, flag %0d, timeout %0d",
                 score_errors, digit_errors, seg_errors, flag_errors, timeout_errors);
        if (total_errors == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* snake_score.f */
snake_score_pkg.sv
score_if.sv
bcd_if.sv
score_tracker.sv
bcd_converter.sv
digit_scanner.sv
snake_score_top.sv
snake_score_tb.sv

/* run_sim.sh */
#!/bin/sh
# Builds the testbench with Verilator, runs it, and fails unless the
# simulator output reports a passing run.
cd "$(dirname "$0")" &&
verilator --binary --timing -j 0 --top-module snake_score_tb \
    -f snake_score.f -o snake_score_sim &&
./obj_dir/snake_score_sim | tee /dev/stderr | grep "TEST PASSED" > /dev/null &&
echo "run_sim: simulation passed" ||
{ echo "run_sim: simulation failed"; exit 1; }
